//--- Makefile
# Verilator build and run of the multiply unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_mfpu -f mfpu.f -Mdir obj_dir
	./obj_dir/Vtb_mfpu | tee /dev/stderr | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

//--- mfpu.f
+incdir+.
mfpu_pkg.sv
mfpu_insn_queue.sv
mfpu_elem_counter.sv
mfpu_simd_mul.sv
mfpu_result_queue.sv
mfpu_top.sv
tb_mfpu.sv

//--- mfpu_elem_counter.sv
/*
 * Element counter for one execution phase
 * Tracks remaining elements, word index and tail byte-enable
 */
`timescale 1ns/10ps
`default_nettype none
`include "mfpu_settings.svh"

module mfpu_elem_counter (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire mfpu_pkg::vinsn_t   insn_i,
  input  wire                     insn_valid_i,
  input  wire                     step_i,
  output logic                    last_o,
  output logic [`MFPU_VL_W-1:0]   word_idx_o,
  output logic [`MFPU_STRB-1:0]   be_o
);

  logic [`MFPU_VL_W-1:0] cnt_q;
  logic                  loaded_q;
  logic [`MFPU_VL_W-1:0] remaining;
  logic [`MFPU_VL_W-1:0] per_word;
  logic [`MFPU_VL_W-1:0] n_elem;
  logic [`MFPU_VL_W-1:0] n_bytes;
  logic [1:0]            idx_shift;

  always_comb begin
    // A fresh instruction starts from its full vl
    remaining = loaded_q ? cnt_q : insn_i.vl;
    per_word  = `MFPU_VL_W'(`MFPU_STRB) >> insn_i.vsew;
    n_elem    = (remaining < per_word) ? remaining : per_word;
    n_bytes   = n_elem << insn_i.vsew;
    idx_shift = 2'($clog2(`MFPU_STRB)) - insn_i.vsew;

    word_idx_o = (insn_i.vl - remaining) >> idx_shift;

    // Only bytes of remaining elements are enabled
    for (int i = 0; i < `MFPU_STRB; i++) begin
      be_o[i] = (`MFPU_VL_W'(i) < n_bytes);
    end
  end

  assign last_o = step_i & insn_valid_i & (remaining <= per_word);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      loaded_q <= 1'b0;
    end else if (insn_valid_i && step_i) begin
      cnt_q    <= remaining - n_elem;
      // Next instruction reloads from its own vl
      loaded_q <= !last_o;
    end
  end

endmodule

`default_nettype wire

//--- mfpu_insn_queue.sv
/*
 * Instruction queue of the multiply unit
 * Circular buffer tracking each instruction through issue, processing and commit
 */
`timescale 1ns/10ps
`default_nettype none
`include "mfpu_settings.svh"

module mfpu_insn_queue (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire mfpu_pkg::vinsn_t        insn_i,
  input  wire                          insn_valid_i,
  output logic                         insn_ready_o,
  input  wire                          issue_last_i,
  input  wire                          proc_last_i,
  input  wire                          commit_last_i,
  output mfpu_pkg::vinsn_t             issue_insn_o,
  output mfpu_pkg::vinsn_t             proc_insn_o,
  output mfpu_pkg::vinsn_t             commit_insn_o,
  output logic                         issue_valid_o,
  output logic                         proc_valid_o,
  output logic                         commit_valid_o,
  output logic [`MFPU_NR_VINSN-1:0]    done_o
);

  localparam int unsigned PntW = $clog2(`MFPU_INSN_DEPTH);
  localparam int unsigned CntW = PntW + 1;

  mfpu_pkg::vinsn_t insn_q [`MFPU_INSN_DEPTH];

  // Depth is a power of two, so the pointers wrap by themselves
  logic [PntW-1:0] accept_pnt_q;
  logic [PntW-1:0] issue_pnt_q;
  logic [PntW-1:0] proc_pnt_q;
  logic [PntW-1:0] commit_pnt_q;

  // Instructions still waiting for each phase to finish
  logic [CntW-1:0] issue_cnt_q;
  logic [CntW-1:0] proc_cnt_q;
  logic [CntW-1:0] commit_cnt_q;

  logic accept;

  // An entry stays held until its commit is done
  assign insn_ready_o = (commit_cnt_q != CntW'(`MFPU_INSN_DEPTH));
  assign accept       = insn_valid_i & insn_ready_o;

  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign proc_insn_o   = insn_q[proc_pnt_q];
  assign commit_insn_o = insn_q[commit_pnt_q];

  assign issue_valid_o  = (issue_cnt_q != '0);
  assign proc_valid_o   = (proc_cnt_q != '0);
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_q + PntW'(accept);
      issue_pnt_q  <= issue_pnt_q + PntW'(issue_last_i);
      proc_pnt_q   <= proc_pnt_q + PntW'(proc_last_i);
      commit_pnt_q <= commit_pnt_q + PntW'(commit_last_i);
      // A new instruction joins all three phases at once
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_last_i);
      proc_cnt_q   <= proc_cnt_q + CntW'(accept) - CntW'(proc_last_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_last_i);
    end
  end

  // Done pulse in the cycle the last word is granted
  always_comb begin
    done_o = '0;
    if (commit_valid_o && commit_last_i) begin
      done_o[commit_insn_o.id] = 1'b1;
    end
  end

  a_commit_cnt_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_cnt_q <= CntW'(`MFPU_INSN_DEPTH))
    else $error("instruction queue holds more than its depth");

endmodule

`default_nettype wire

//--- mfpu_pkg.sv
/*
 * Vector multiply unit types
 * Operation encodings, instruction and operand structs, lane view of a word
 */
`default_nettype none
`include "mfpu_settings.svh"

package mfpu_pkg;

  typedef logic [`MFPU_ELEN-1:0]             elen_t;
  typedef logic [`MFPU_STRB-1:0]             strb_t;
  typedef logic [$clog2(`MFPU_NR_VINSN)-1:0] vid_t;
  typedef logic [`MFPU_VL_W-1:0]             vlen_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef enum logic {
    VMUL  = 1'b0,
    VMACC = 1'b1
  } mul_op_e;

  typedef struct packed {
    vid_t       id;
    mul_op_e    op;
    vsew_e      vsew;
    vlen_t      vl;
    logic [4:0] vd;
    logic       use_scalar;
    elen_t      scalar;
  } vinsn_t;

  typedef struct packed {
    elen_t vs1;
    elen_t vs2;
    elen_t vd;
  } operands_t;

  // One word split into lanes, picked by vsew
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    elen_t            d;
  } elen_lanes_u;

  typedef struct packed {
    elen_lanes_u a;
    elen_lanes_u b;
    elen_lanes_u c;
    strb_t       be;
  } mul_req_t;

  typedef struct packed {
    elen_t wdata;
    strb_t be;
  } mul_rsp_t;

  typedef struct packed {
    vid_t                    id;
    logic [`MFPU_ADDR_W-1:0] addr;
    elen_t                   wdata;
    strb_t                   be;
  } result_t;

endpackage

`default_nettype wire

//--- mfpu_result_queue.sv
/*
 * Result queue of the multiply unit
 * Two-entry buffer that forms the address and writes the register file
 */
`timescale 1ns/10ps
`default_nettype none
`include "mfpu_settings.svh"

module mfpu_result_queue (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire mfpu_pkg::mul_rsp_t  rsp_i,
  input  wire                      rsp_valid_i,
  output logic                     rsp_ready_o,
  input  wire mfpu_pkg::vinsn_t    proc_insn_i,
  input  wire [`MFPU_VL_W-1:0]     word_idx_i,
  output mfpu_pkg::result_t        result_o,
  output logic                     result_req_o,
  input  wire                      result_gnt_i,
  output logic                     gnt_o
);

  localparam int unsigned Depth = `MFPU_RESULT_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);
  localparam int unsigned CntW  = PntW + 1;

  mfpu_pkg::result_t       entry_q [Depth];
  mfpu_pkg::result_t       entry_d;
  logic [PntW-1:0]         wr_pnt_q;
  logic [PntW-1:0]         rd_pnt_q;
  logic [CntW-1:0]         cnt_q;
  logic                    wr_en;
  logic [`MFPU_ADDR_W-1:0] vreg_base;

  assign rsp_ready_o  = (cnt_q != CntW'(Depth));
  assign wr_en        = rsp_valid_i & rsp_ready_o;
  assign result_req_o = (cnt_q != '0);
  assign result_o     = entry_q[rd_pnt_q];
  assign gnt_o        = result_req_o & result_gnt_i;

  // First word of vd within this lane
  assign vreg_base = `MFPU_ADDR_W'(proc_insn_i.vd) * `MFPU_ADDR_W'(`MFPU_VREG_WORDS);

  always_comb begin
    entry_d.id    = proc_insn_i.id;
    entry_d.addr  = vreg_base + `MFPU_ADDR_W'(word_idx_i);
    entry_d.wdata = rsp_i.wdata;
    entry_d.be    = rsp_i.be;
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      entry_q[wr_pnt_q] <= entry_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_pnt_q <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (gnt_o) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(wr_en) - CntW'(gnt_o);
    end
  end

  // A response refused by a full queue is still offered next cycle
  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_o |=> rsp_valid_i)
    else $error("response lost while result queue was full");

endmodule

`default_nettype wire

//--- mfpu_settings.svh
/*
 * Vector multiply unit settings
 * Datapath widths, queue depths and multiplier latency
 */
`ifndef MFPU_SETTINGS_SVH
`define MFPU_SETTINGS_SVH

// Datapath word and its byte-enable
`define MFPU_ELEN 64
`define MFPU_STRB 8

// Queue depths
`define MFPU_INSN_DEPTH 4
`define MFPU_RESULT_DEPTH 2

// Multiplier pipeline stages
`define MFPU_MUL_LATENCY 3

// Instruction ids and vector length
`define MFPU_NR_VINSN 8
`define MFPU_VL_W 8

// Register file geometry of this lane
`define MFPU_VREG_WORDS 16
`define MFPU_ADDR_W 9

`endif

//--- mfpu_simd_mul.sv
/*
 * SIMD integer multiplier
 * Lane-wise low product with optional accumulate, in a stallable pipeline
 */
`timescale 1ns/10ps
`default_nettype none
`include "mfpu_settings.svh"

module mfpu_simd_mul (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire mfpu_pkg::vinsn_t     insn_i,
  input  wire mfpu_pkg::operands_t  operands_i,
  input  wire [`MFPU_STRB-1:0]      be_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  output mfpu_pkg::mul_rsp_t        rsp_o,
  output logic                      out_valid_o,
  input  wire                       out_ready_i
);

  localparam int unsigned Lat = `MFPU_MUL_LATENCY;

  mfpu_pkg::elen_t       scalar_rep;
  mfpu_pkg::mul_req_t    req;
  mfpu_pkg::elen_lanes_u prod;
  mfpu_pkg::mul_rsp_t    pipe_q [Lat];
  logic [Lat-1:0]        valid_q;
  logic                  advance;

  // Scalar broadcast to every lane of the word
  always_comb begin
    case (insn_i.vsew)
      mfpu_pkg::EW8:  scalar_rep = {8{insn_i.scalar[7:0]}};
      mfpu_pkg::EW16: scalar_rep = {4{insn_i.scalar[15:0]}};
      mfpu_pkg::EW32: scalar_rep = {2{insn_i.scalar[31:0]}};
      default:        scalar_rep = insn_i.scalar;
    endcase
  end

  always_comb begin
    req.a.d = insn_i.use_scalar ? scalar_rep : operands_i.vs1;
    req.b.d = operands_i.vs2;
    // Accumulator is zero for a plain multiply
    req.c.d = (insn_i.op == mfpu_pkg::VMACC) ? operands_i.vd : '0;
    req.be  = be_i;
  end

  // Low half of each lane product plus vd
  always_comb begin
    prod = '0;
    case (insn_i.vsew)
      mfpu_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          prod.b[i] = req.a.b[i] * req.b.b[i] + req.c.b[i];
        end
      end
      mfpu_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          prod.h[i] = req.a.h[i] * req.b.h[i] + req.c.h[i];
        end
      end
      mfpu_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          prod.w[i] = req.a.w[i] * req.b.w[i] + req.c.w[i];
        end
      end
      default: prod.d = req.a.d * req.b.d + req.c.d;
    endcase
  end

  // Whole pipeline holds while the output waits
  assign advance     = !out_valid_o || out_ready_i;
  assign in_ready_o  = advance;
  assign out_valid_o = valid_q[Lat-1];
  assign rsp_o       = pipe_q[Lat-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= in_valid_i;
      for (int s = 1; s < Lat; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      pipe_q[0].wdata <= prod.d;
      pipe_q[0].be    <= req.be;
      for (int s = 1; s < Lat; s++) begin
        pipe_q[s] <= pipe_q[s-1];
      end
    end
  end

  a_out_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o))
    else $error("multiplier output dropped or changed while stalled");

endmodule

`default_nettype wire

//--- mfpu_top.sv
/*
 * Vector integer multiply unit, one lane
 * Instruction queue, phase counters, SIMD multiplier and result queue
 */
`timescale 1ns/10ps
`default_nettype none
`include "mfpu_settings.svh"

module mfpu_top (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire mfpu_pkg::vinsn_t     insn_i,
  input  wire                       insn_valid_i,
  output logic                      insn_ready_o,
  input  wire mfpu_pkg::operands_t  operands_i,
  input  wire                       operands_valid_i,
  output logic                      operands_ready_o,
  output mfpu_pkg::result_t         result_o,
  output logic                      result_req_o,
  input  wire                       result_gnt_i,
  output logic [`MFPU_NR_VINSN-1:0] done_o
);

  mfpu_pkg::vinsn_t      issue_insn;
  mfpu_pkg::vinsn_t      proc_insn;
  mfpu_pkg::vinsn_t      commit_insn;
  logic                  issue_valid;
  logic                  proc_valid;
  logic                  commit_valid;
  logic                  issue_last;
  logic                  proc_last;
  logic                  commit_last;
  logic                  issue_step;
  logic                  proc_step;
  logic [`MFPU_STRB-1:0] issue_be;
  logic [`MFPU_VL_W-1:0] proc_word_idx;
  logic                  mul_in_valid;
  logic                  mul_in_ready;
  mfpu_pkg::mul_rsp_t    mul_rsp;
  logic                  mul_out_valid;
  logic                  rq_ready;
  logic                  rq_gnt;

  // Operand handshake only while an instruction is in issue
  assign mul_in_valid     = issue_valid & operands_valid_i;
  assign operands_ready_o = issue_valid & mul_in_ready;
  assign issue_step       = mul_in_valid & mul_in_ready;
  assign proc_step        = mul_out_valid & rq_ready;

  mfpu_insn_queue u_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn_i),
    .insn_valid_i   (insn_valid_i),
    .insn_ready_o   (insn_ready_o),
    .issue_last_i   (issue_last),
    .proc_last_i    (proc_last),
    .commit_last_i  (commit_last),
    .issue_insn_o   (issue_insn),
    .proc_insn_o    (proc_insn),
    .commit_insn_o  (commit_insn),
    .issue_valid_o  (issue_valid),
    .proc_valid_o   (proc_valid),
    .commit_valid_o (commit_valid),
    .done_o         (done_o)
  );

  mfpu_elem_counter u_issue_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (issue_insn),
    .insn_valid_i (issue_valid),
    .step_i       (issue_step),
    .last_o       (issue_last),
    .word_idx_o   (),
    .be_o         (issue_be)
  );

  mfpu_elem_counter u_proc_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (proc_insn),
    .insn_valid_i (proc_valid),
    .step_i       (proc_step),
    .last_o       (proc_last),
    .word_idx_o   (proc_word_idx),
    .be_o         ()
  );

  mfpu_elem_counter u_commit_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (commit_insn),
    .insn_valid_i (commit_valid),
    .step_i       (rq_gnt),
    .last_o       (commit_last),
    .word_idx_o   (),
    .be_o         ()
  );

  mfpu_simd_mul u_simd_mul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .insn_i      (issue_insn),
    .operands_i  (operands_i),
    .be_i        (issue_be),
    .in_valid_i  (mul_in_valid),
    .in_ready_o  (mul_in_ready),
    .rsp_o       (mul_rsp),
    .out_valid_o (mul_out_valid),
    .out_ready_i (rq_ready)
  );

  mfpu_result_queue u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp_i        (mul_rsp),
    .rsp_valid_i  (mul_out_valid),
    .rsp_ready_o  (rq_ready),
    .proc_insn_i  (proc_insn),
    .word_idx_i   (proc_word_idx),
    .result_o     (result_o),
    .result_req_o (result_req_o),
    .result_gnt_i (result_gnt_i),
    .gnt_o        (rq_gnt)
  );

endmodule

`default_nettype wire

//--- tb_mfpu.sv
/*
 * Testbench of the vector multiply unit
 * Random operands and grant gaps, reference model and checking assertions
 */
`timescale 1ns/10ps
`default_nettype none
`include "mfpu_settings.svh"

module tb_mfpu;

  logic                       clk_i;
  logic                       rst_ni;
  mfpu_pkg::vinsn_t           insn_i;
  logic                       insn_valid_i;
  logic                       insn_ready_o;
  mfpu_pkg::operands_t        operands_i;
  logic                       operands_valid_i;
  logic                       operands_ready_o;
  mfpu_pkg::result_t          result_o;
  logic                       result_req_o;
  logic                       result_gnt_i;
  logic [`MFPU_NR_VINSN-1:0]  done_o;

  // Expected result stream, one entry per operand word sent
  mfpu_pkg::result_t          exp_res [1024];
  logic                       exp_last [1024];
  int                         exp_wr;
  int                         exp_rd;
  mfpu_pkg::result_t          exp_head;
  logic                       exp_head_last;
  logic [`MFPU_NR_VINSN-1:0]  exp_done;
  logic                       gnt_fire;

  mfpu_pkg::vinsn_t           prog [$];
  mfpu_pkg::vid_t             next_id;
  int                         held_cnt;
  int                         acc_cnt;
  int                         issued_cnt;
  int                         words_planned;
  int                         chk_cnt;
  int                         err_cnt;
  int                         cycles;
  logic                       gnt_block;
  logic [31:0]                op_lfsr;
  logic [31:0]                gnt_lfsr;
  string                      test_name;

  mfpu_top u_mfpu_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn_i           (insn_i),
    .insn_valid_i     (insn_valid_i),
    .insn_ready_o     (insn_ready_o),
    .operands_i       (operands_i),
    .operands_valid_i (operands_valid_i),
    .operands_ready_o (operands_ready_o),
    .result_o         (result_o),
    .result_req_o     (result_req_o),
    .result_gnt_i     (result_gnt_i),
    .done_o           (done_o)
  );

  assign gnt_fire      = result_req_o & result_gnt_i;
  assign exp_head      = exp_res[exp_rd];
  assign exp_head_last = exp_last[exp_rd];
  assign exp_done      = (gnt_fire && exp_head_last) ?
                         (`MFPU_NR_VINSN'(1) << exp_head.id) : '0;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ 32'hD000_0001) : {1'b0, s[31:1]};
  endfunction

  function automatic int word_count(input int vl, input int sew);
    int epw;
    epw = 8 >> sew;
    return (vl + epw - 1) / epw;
  endfunction

  // Bytes of the elements left in word k
  function automatic logic [7:0] tail_be(input int vl, input int sew, input int k);
    int epw;
    int rem;
    epw = 8 >> sew;
    rem = vl - k * epw;
    if (rem > epw) begin
      rem = epw;
    end
    return 8'((1 << (rem << sew)) - 1);
  endfunction

  function automatic logic [63:0] lane_mask(input int w);
    return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
  endfunction

  function automatic logic [63:0] splat(input logic [63:0] s, input int sew);
    int          w;
    logic [63:0] res;
    w   = 8 << sew;
    res = '0;
    for (int k = 0; k < 64 / w; k++) begin
      res |= (s & lane_mask(w)) << (k * w);
    end
    return res;
  endfunction

  // Lane-wise a times b plus c, wrapped to the lane width
  function automatic logic [63:0] lane_mac(input logic [63:0] a, input logic [63:0] b,
                                           input logic [63:0] c, input int sew);
    int          w;
    logic [63:0] m;
    logic [63:0] res;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] z;
    w   = 8 << sew;
    m   = lane_mask(w);
    res = '0;
    for (int k = 0; k < 64 / w; k++) begin
      x = (a >> (k * w)) & m;
      y = (b >> (k * w)) & m;
      z = (c >> (k * w)) & m;
      res |= ((x * y + z) & m) << (k * w);
    end
    return res;
  endfunction

  task automatic add_insn(input mfpu_pkg::mul_op_e op, input mfpu_pkg::vsew_e sew,
                          input int vl, input int vd, input logic use_scalar,
                          input logic [63:0] scalar);
    mfpu_pkg::vinsn_t insn;
    insn.id         = next_id;
    insn.op         = op;
    insn.vsew       = sew;
    insn.vl         = `MFPU_VL_W'(vl);
    insn.vd         = 5'(vd);
    insn.use_scalar = use_scalar;
    insn.scalar     = scalar;
    next_id         = next_id + 1'b1;
    prog.push_back(insn);
    words_planned  += word_count(vl, int'(sew));
  endtask

  // Ready only changes at the rising edge, so it is read at the falling edge
  task automatic send_insns();
    foreach (prog[i]) begin
      @(negedge clk_i);
      insn_i       = prog[i];
      insn_valid_i = 1'b1;
      while (!insn_ready_o) @(negedge clk_i);
      @(posedge clk_i);
    end
    @(negedge clk_i);
    insn_valid_i = 1'b0;
  endtask

  task automatic send_operands();
    mfpu_pkg::vinsn_t    insn;
    mfpu_pkg::operands_t ops;
    mfpu_pkg::result_t   exp;
    logic [63:0]         a;
    int                  nw;
    foreach (prog[i]) begin
      insn = prog[i];
      nw   = word_count(int'(insn.vl), int'(insn.vsew));
      for (int k = 0; k < nw; k++) begin
        @(negedge clk_i);
        for (int j = 0; j < $bits(ops); j++) begin
          ops[j]  = op_lfsr[0];
          op_lfsr = lfsr_next(op_lfsr);
        end
        operands_i       = ops;
        operands_valid_i = 1'b1;
        while (!operands_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        a         = insn.use_scalar ? splat(insn.scalar, int'(insn.vsew)) : ops.vs1;
        exp.id    = insn.id;
        exp.addr  = `MFPU_ADDR_W'(int'(insn.vd) * `MFPU_VREG_WORDS + k);
        exp.wdata = lane_mac(a, ops.vs2, (insn.op == mfpu_pkg::VMACC) ? ops.vd : 64'd0,
                             int'(insn.vsew));
        exp.be    = tail_be(int'(insn.vl), int'(insn.vsew), k);
        exp_res[exp_wr]  = exp;
        exp_last[exp_wr] = (k == nw - 1);
        exp_wr++;
        if (k == nw - 1) begin
          issued_cnt++;
        end
      end
    end
    @(negedge clk_i);
    operands_valid_i = 1'b0;
  endtask

  task automatic run_prog(input string name);
    test_name = name;
    fork
      send_insns();
      send_operands();
    join
    // Drain until every word is granted and every instruction committed
    while (exp_rd != exp_wr || held_cnt != 0) @(negedge clk_i);
    prog.delete();
  endtask

  // Grant gaps, high three times out of four
  initial begin
    result_gnt_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (gnt_block) begin
        result_gnt_i = 1'b0;
      end else begin
        result_gnt_i = gnt_lfsr[0];
        gnt_lfsr     = lfsr_next(gnt_lfsr);
        result_gnt_i = result_gnt_i | gnt_lfsr[0];
        gnt_lfsr     = lfsr_next(gnt_lfsr);
      end
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_cnt <= 0;
      acc_cnt  <= 0;
      exp_rd   <= 0;
      chk_cnt  <= 0;
    end else begin
      held_cnt <= held_cnt + ((insn_valid_i && insn_ready_o) ? 1 : 0)
                           - ((gnt_fire && exp_head_last) ? 1 : 0);
      acc_cnt  <= acc_cnt + ((insn_valid_i && insn_ready_o) ? 1 : 0);
      if (gnt_fire) begin
        exp_rd  <= exp_rd + 1;
        chk_cnt <= chk_cnt + 1;
      end
    end
  end

  a_reset_state : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> insn_ready_o && !result_req_o && done_o == '0)
    else begin
      err_cnt++;
      $display("Outputs not idle after reset: ready %b req %b done %b",
               insn_ready_o, result_req_o, done_o);
    end

  a_result_expected : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_fire |-> exp_rd < exp_wr)
    else begin
      err_cnt++;
      $display("%s: a result was granted that no operand word accounts for", test_name);
    end

  a_result_match : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_fire |-> result_o == exp_head)
    else begin
      err_cnt++;
      $display("** Error %s: expected id %0d addr %0d data %h be %b, ",
               test_name, exp_head.id, exp_head.addr, exp_head.wdata, exp_head.be,
               "actual id %0d addr %0d data %h be %b",
               result_o.id, result_o.addr, result_o.wdata, result_o.be);
    end

  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o == exp_done)
    else begin
      err_cnt++;
      $display("** Error %s: done expected %b actual %b", test_name, exp_done, done_o);
    end

  a_insn_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_ready_o == (held_cnt < `MFPU_INSN_DEPTH))
    else begin
      err_cnt++;
      $display("** Error %s: insn_ready expected %b actual %b", test_name,
               held_cnt < `MFPU_INSN_DEPTH, insn_ready_o);
    end

  // Operands are taken only for an instruction in issue and with room downstream
  a_operands_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    operands_ready_o |-> (acc_cnt > issued_cnt) &&
      (exp_wr - exp_rd < `MFPU_MUL_LATENCY + `MFPU_RESULT_DEPTH))
    else begin
      err_cnt++;
      $display("%s: operands accepted with no instruction in issue or a full pipeline",
               test_name);
    end

  a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o))
    else begin
      err_cnt++;
      $display("%s: result request dropped or changed before its grant", test_name);
    end

  // Limit grows with the words queued by the tests
  initial begin
    cycles = 0;
    while (cycles <= 1000 + 200 * words_planned) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run still busy after %0d cycles in test %s", cycles, test_name);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst_ni           = 1'b0;
    insn_i           = '0;
    insn_valid_i     = 1'b0;
    operands_i       = '0;
    operands_valid_i = 1'b0;
    gnt_block        = 1'b0;
    op_lfsr          = 32'h5667;
    gnt_lfsr         = 32'h5667;
    next_id          = '0;
    exp_wr           = 0;
    issued_cnt       = 0;
    words_planned    = 0;
    err_cnt          = 0;
    test_name        = "reset";
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW8, 16, 1, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW16, 8, 2, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW32, 4, 3, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW64, 2, 4, 1'b0, '0);
    run_prog("vmul_vv");

    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW8, 16, 5, 1'b1, 64'hA5C3_0F12_3456_79E3);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW16, 8, 6, 1'b1, 64'h1111_2222_3333_F00D);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW32, 4, 7, 1'b1, 64'hDEAD_BEEF_8000_0003);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW64, 2, 8, 1'b1, 64'hFEDC_BA98_7654_3211);
    run_prog("vmul_vx");

    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW8, 16, 9, 1'b0, '0);
    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW16, 8, 10, 1'b0, '0);
    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW32, 4, 11, 1'b1, 64'h0000_0001_0000_7FFF);
    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW64, 2, 12, 1'b0, '0);
    run_prog("vmacc");

    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW8, 13, 13, 1'b0, '0);
    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW16, 7, 14, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW32, 3, 15, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW8, 1, 16, 1'b1, 64'h0000_0000_0000_00FF);
    run_prog("tail_be");

    // Grant held low until the queue fills and refuses the fifth instruction
    gnt_block = 1'b1;
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW64, 2, 17, 1'b0, '0);
    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW32, 5, 18, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW16, 6, 19, 1'b1, 64'h0000_0000_0000_ABCD);
    add_insn(mfpu_pkg::VMACC, mfpu_pkg::EW8, 20, 20, 1'b0, '0);
    add_insn(mfpu_pkg::VMUL, mfpu_pkg::EW64, 3, 21, 1'b0, '0);
    fork
      run_prog("backpressure");
      begin
        while (insn_ready_o) @(negedge clk_i);
        repeat (8) @(negedge clk_i);
        gnt_block = 1'b0;
      end
    join

    $display("Run complete: %0d results checked, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
